/* bpChk.sv */
`timescale 1ns/1ns
`default_nettype none

module bpChk import bpPkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   predTaken,
    input logic   predHit,
    input logic   retPush,
    input logic   retPop,
    input logic   mispr,
    input bHist_t misprHist,
    input bHist_t history
);

    // taken only on a btb hit.
    takenNeedsHit: assert property (@(posedge clk) disable iff (rst)
        predTaken |-> predHit)
        else $error("predTaken is high while predHit is low");

    pushPopExclusive: assert property (@(posedge clk) disable iff (rst)
        !(retPush && retPop))
        else $error("return stack push and pop in the same cycle");

    // restore lands one cycle later.
    misprRestore: assert property (@(posedge clk) disable iff (rst)
        mispr |=> (history == $past(misprHist)))
        else $error("history does not match the restored value after mispr");

endmodule

bind branchPredictor bpChk chk0 (
    .clk       (clk),
    .rst       (rst),
    .predTaken (predTaken),
    .predHit   (predHit),
    .retPush   (retPush),
    .retPop    (retPop),
    .mispr     (mispr),
    .misprHist (misprHist),
    .history   (history)
);

`default_nettype wire

/* bpPkg.sv */
`default_nettype none

package bpPkg;

    // ##############################
    // widths and table sizes
    localparam int addrBits    = 30;
    localparam int histBits    = 8;
    localparam int retDepth    = 8;
    localparam int retIdxBits  = $clog2(retDepth);
    localparam int btbEntries  = 16;
    localparam int btbIdxBits  = $clog2(btbEntries);
    localparam int btbTagBits  = 10;
    localparam int baseEntries = 64;
    localparam int baseIdxBits = $clog2(baseEntries);
    localparam int tagEntries  = 16;
    localparam int tagIdxBits  = $clog2(tagEntries);
    localparam int tagTagBits  = 4;

    typedef logic [addrBits-1:0]    addr_t;     // pc bits 31..2.
    typedef logic [histBits-1:0]    bHist_t;    // newest outcome in bit 0.
    typedef logic [retIdxBits-1:0]  retIdx_t;
    typedef logic [1:0]             ctr_t;      // taken when msb set.
    typedef logic [btbIdxBits-1:0]  btbIdx_t;
    typedef logic [btbTagBits-1:0]  btbTag_t;
    typedef logic [baseIdxBits-1:0] baseIdx_t;
    typedef logic [tagIdxBits-1:0]  tagIdx_t;
    typedef logic [tagTagBits-1:0]  tagTag_t;

    typedef enum logic [1:0] {
        kindCond,
        kindJump,
        kindCall,
        kindRet
    } brKind_t;

    localparam ctr_t ctrWeakNotTaken = 2'd1;
    localparam ctr_t ctrWeakTaken    = 2'd2;

    // ##############################
    // index and tag helpers
    function automatic btbIdx_t btbIndex(addr_t a);
        return a[btbIdxBits-1:0];
    endfunction

    function automatic btbTag_t btbTag(addr_t a);
        return a[btbIdxBits+btbTagBits-1:btbIdxBits];
    endfunction

    function automatic baseIdx_t baseIndex(addr_t a);
        return a[baseIdxBits-1:0];
    endfunction

    function automatic tagIdx_t tagIndex(addr_t a, bHist_t h);
        return a[tagIdxBits-1:0] ^ h[tagIdxBits-1:0];
    endfunction

    function automatic tagTag_t tagTag(addr_t a);
        return a[tagIdxBits+tagTagBits-1:tagIdxBits];
    endfunction

    // saturating move toward the outcome.
    function automatic ctr_t ctrNext(ctr_t c, logic taken);
        if (taken)
            return (c == 2'd3) ? c : c + 2'd1;
        else
            return (c == 2'd0) ? c : c - 2'd1;
    endfunction

endpackage

`default_nettype wire

/* bpTb.sv */
`timescale 1ns/1ns
`default_nettype none

module bpTb import bpPkg::*; ();

    logic        clk = 1'b0;
    logic        rst;
    logic        pcValid;
    logic [31:0] pc;
    logic        btUpdValid;
    logic [31:0] btUpdPc;
    logic [31:0] btUpdTarget;
    brKind_t     btUpdKind;
    logic        bpUpdValid;
    logic [31:0] bpUpdPc;
    bHist_t      bpUpdHistory;
    logic        bpUpdTaken;
    logic        bpUpdPredTaken;
    logic        bpUpdProvider;
    logic        mispr;
    bHist_t      misprHist;
    retIdx_t     misprRetIdx;

    logic        predTaken;
    logic [31:0] predTarget;
    brKind_t     predKind;
    logic        predHit;
    bHist_t      history;
    logic        provider;
    retIdx_t     retIdx;

    // values sampled during the last lookup.
    logic        lkTaken;
    logic [31:0] lkTarget;
    brKind_t     lkKind;
    logic        lkHit;
    logic        lkProvider;
    bHist_t      curHist;
    retIdx_t     curRet;

    string       curTest;
    int          errCount = 0;
    int          checkCount = 0;
    int          testCount = 0;
    int          testStartErr;
    logic [31:0] condPc;
    logic [31:0] callPc;
    bHist_t      trainHist;

    branchPredictor dut0 (
        .clk            (clk),
        .rst            (rst),
        .pcValid        (pcValid),
        .pc             (pc),
        .predTaken      (predTaken),
        .predTarget     (predTarget),
        .predKind       (predKind),
        .predHit        (predHit),
        .history        (history),
        .provider       (provider),
        .retIdx         (retIdx),
        .btUpdValid     (btUpdValid),
        .btUpdPc        (btUpdPc),
        .btUpdTarget    (btUpdTarget),
        .btUpdKind      (btUpdKind),
        .bpUpdValid     (bpUpdValid),
        .bpUpdPc        (bpUpdPc),
        .bpUpdHistory   (bpUpdHistory),
        .bpUpdTaken     (bpUpdTaken),
        .bpUpdPredTaken (bpUpdPredTaken),
        .bpUpdProvider  (bpUpdProvider),
        .mispr          (mispr),
        .misprHist      (misprHist),
        .misprRetIdx    (misprRetIdx)
    );

    always #10 clk = ~clk;

    // ##############################
    // helpers
    task automatic checkVal(input string what, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errCount++;
            $display("Error %s %s: expected %h, actual %h", curTest, what, expVal, actVal);
        end
    endtask

    function automatic logic [31:0] makePc(input logic [3:0] idx);
        logic [31:0] r;
        r = $urandom();
        return {r[31:6], idx, 2'b00}; // fixed btb index, random tag.
    endfunction

    function automatic logic [31:0] randTarget();
        logic [31:0] r;
        r = $urandom();
        return {r[31:2], 2'b00};
    endfunction

    task automatic readState();
        @(negedge clk);
        curHist = history;
        curRet  = retIdx;
    endtask

    task automatic installBranch(input logic [31:0] pcIn, input logic [31:0] tgt,
                                 input brKind_t k);
        @(posedge clk);
        btUpdValid  <= 1'b1;
        btUpdPc     <= pcIn;
        btUpdTarget <= tgt;
        btUpdKind   <= k;
        @(posedge clk);
        btUpdValid  <= 1'b0;
    endtask

    // one fetch cycle, outputs sampled mid-cycle.
    task automatic doLookup(input logic [31:0] pcIn);
        @(posedge clk);
        pcValid <= 1'b1;
        pc      <= pcIn;
        @(negedge clk);
        lkTaken    = predTaken;
        lkTarget   = predTarget;
        lkKind     = predKind;
        lkHit      = predHit;
        lkProvider = provider;
        @(posedge clk);
        pcValid <= 1'b0;
    endtask

    task automatic commitDir(input logic [31:0] pcIn, input bHist_t h, input logic taken,
                             input logic predT, input logic prov, input logic withMispr,
                             input retIdx_t rIdx);
        @(posedge clk);
        bpUpdValid     <= 1'b1;
        bpUpdPc        <= pcIn;
        bpUpdHistory   <= h;
        bpUpdTaken     <= taken;
        bpUpdPredTaken <= predT;
        bpUpdProvider  <= prov;
        mispr          <= withMispr;
        misprHist      <= h;
        misprRetIdx    <= rIdx;
        @(posedge clk);
        bpUpdValid <= 1'b0;
        mispr      <= 1'b0;
    endtask

    task automatic restoreState(input bHist_t h, input retIdx_t idx);
        @(posedge clk);
        mispr       <= 1'b1;
        misprHist   <= h;
        misprRetIdx <= idx;
        @(posedge clk);
        mispr <= 1'b0;
        readState();
        checkVal("restored history", 32'(h), 32'(curHist));
        checkVal("restored retIdx", 32'(idx), 32'(curRet));
    endtask

    task automatic endTest();
        testCount++;
        $display("test %s %s", curTest, (errCount == testStartErr) ? "ok" : "failed");
    endtask

    task automatic waitReady(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < 20) begin
            @(negedge clk);
            ok = !rst && (history == '0) && (retIdx == '0);
            cycles++;
        end
    endtask

    // ##############################
    // tests
    task automatic testResetLookups();
        curTest = "resetLookups";
        testStartErr = errCount;
        for (int i = 0; i < 8; i++) begin
            doLookup(randTarget());
            checkVal("predHit", 32'd0, 32'(lkHit));
            checkVal("predTaken", 32'd0, 32'(lkTaken));
            readState();
            checkVal("history", 32'd0, 32'(curHist));
            checkVal("retIdx", 32'd0, 32'(curRet));
        end
        endTest();
    endtask

    task automatic testBtbInstall();
        logic [31:0] pcA;
        logic [31:0] pcB;
        logic [31:0] tgtA;
        logic [31:0] tgtB;
        curTest = "btbInstall";
        testStartErr = errCount;
        pcA  = makePc(4'd1);
        pcB  = pcA ^ 32'h0000_0040; // same index, tag bit 0 flipped.
        tgtA = randTarget();
        tgtB = randTarget();
        installBranch(pcA, tgtA, kindJump);
        doLookup(pcA);
        checkVal("jump hit", 32'd1, 32'(lkHit));
        checkVal("jump taken", 32'd1, 32'(lkTaken));
        checkVal("jump target", tgtA, lkTarget);
        checkVal("jump kind", 32'(kindJump), 32'(lkKind));
        doLookup(pcB);
        checkVal("alias hit", 32'd0, 32'(lkHit));
        checkVal("alias taken", 32'd0, 32'(lkTaken));
        installBranch(pcB, tgtB, kindJump);
        doLookup(pcB);
        checkVal("replaced hit", 32'd1, 32'(lkHit));
        checkVal("replaced target", tgtB, lkTarget);
        doLookup(pcA);
        checkVal("evicted hit", 32'd0, 32'(lkHit));
        endTest();
    endtask

    task automatic testCondTraining();
        curTest = "condTraining";
        testStartErr = errCount;
        condPc    = makePc(4'd2);
        trainHist = bHist_t'($urandom());
        installBranch(condPc, randTarget(), kindCond);
        readState();
        restoreState(trainHist, curRet);
        doLookup(condPc); // base counter weakly not taken.
        checkVal("cond hit", 32'd1, 32'(lkHit));
        checkVal("initial taken", 32'd0, 32'(lkTaken));
        readState();
        checkVal("history shift", 32'({trainHist[6:0], 1'b0}), 32'(curHist));
        restoreState(trainHist, curRet);
        for (int i = 0; i < 4; i++) begin
            commitDir(condPc, trainHist, 1'b1, 1'b0, 1'b0, 1'b0, curRet);
        end
        doLookup(condPc);
        checkVal("trained taken", 32'd1, 32'(lkTaken));
        checkVal("tagged provider", 32'd1, 32'(lkProvider));
        readState();
        checkVal("history shift", 32'({trainHist[6:0], 1'b1}), 32'(curHist));
        restoreState(trainHist, curRet);
        for (int i = 0; i < 4; i++) begin
            commitDir(condPc, trainHist, 1'b0, 1'b1, 1'b1, 1'b0, curRet);
        end
        doLookup(condPc);
        checkVal("retrained taken", 32'd0, 32'(lkTaken));
        readState();
        checkVal("history shift", 32'({trainHist[6:0], 1'b0}), 32'(curHist));
        endTest();
    endtask

    task automatic testReturnStack();
        logic [31:0] callB;
        logic [31:0] retPc;
        logic [31:0] tgtA;
        logic [31:0] tgtB;
        retIdx_t     baseRet;
        curTest = "returnStack";
        testStartErr = errCount;
        callPc = makePc(4'd3);
        callB  = makePc(4'd4);
        retPc  = makePc(4'd5);
        tgtA   = randTarget();
        tgtB   = randTarget();
        installBranch(callPc, tgtA, kindCall);
        installBranch(callB, tgtB, kindCall);
        installBranch(retPc, randTarget(), kindRet);
        readState();
        baseRet = '0; // nothing pushed yet.
        checkVal("retIdx before calls", 32'(baseRet), 32'(curRet));
        doLookup(callPc);
        checkVal("call taken", 32'd1, 32'(lkTaken));
        checkVal("call target", tgtA, lkTarget);
        checkVal("call kind", 32'(kindCall), 32'(lkKind));
        readState();
        checkVal("retIdx after push", 32'(retIdx_t'(baseRet + 3'd1)), 32'(curRet));
        doLookup(callB);
        readState();
        checkVal("retIdx after push", 32'(retIdx_t'(baseRet + 3'd2)), 32'(curRet));
        // returns come back newest first.
        doLookup(retPc);
        checkVal("ret taken", 32'd1, 32'(lkTaken));
        checkVal("ret target", callB + 32'd4, lkTarget);
        checkVal("ret kind", 32'(kindRet), 32'(lkKind));
        readState();
        checkVal("retIdx after pop", 32'(retIdx_t'(baseRet + 3'd1)), 32'(curRet));
        doLookup(retPc);
        checkVal("ret target", callPc + 32'd4, lkTarget);
        readState();
        checkVal("retIdx after pop", 32'(baseRet), 32'(curRet));
        endTest();
    endtask

    task automatic testMispredict();
        bHist_t  expHist;
        retIdx_t expRet;
        bHist_t  newHist;
        retIdx_t newIdx;
        curTest = "mispredict";
        testStartErr = errCount;
        expHist = {trainHist[6:0], 1'b0}; // left by the last training lookup.
        expRet  = '0;
        readState();
        checkVal("history before", 32'(expHist), 32'(curHist));
        for (int i = 0; i < 3; i++) begin
            doLookup(condPc);
            checkVal("cond hit", 32'd1, 32'(lkHit));
            checkVal("cond taken", 32'd0, 32'(lkTaken)); // counters saturated not taken.
            expHist = {expHist[6:0], 1'b0};
            readState();
            checkVal("history shift", 32'(expHist), 32'(curHist));
        end
        doLookup(callPc);
        readState();
        checkVal("retIdx after call", 32'(retIdx_t'(expRet + 3'd1)), 32'(curRet));
        newHist = bHist_t'($urandom());
        newIdx  = retIdx_t'($urandom());
        restoreState(newHist, newIdx);
        // commits alongside mispr must be dropped.
        restoreState(trainHist, newIdx);
        for (int i = 0; i < 4; i++) begin
            commitDir(condPc, trainHist, 1'b1, 1'b0, 1'b1, 1'b1, newIdx);
        end
        readState();
        checkVal("history held", 32'(trainHist), 32'(curHist));
        doLookup(condPc);
        checkVal("gated commit taken", 32'd0, 32'(lkTaken));
        endTest();
    endtask

    // ##############################
    // main sequence
    initial begin
        bit          ready;
        int unsigned seedVal;
        seedVal        = $urandom(45);
        rst            <= 1'b1;
        pcValid        <= 1'b0;
        pc             <= '0;
        btUpdValid     <= 1'b0;
        btUpdPc        <= '0;
        btUpdTarget    <= '0;
        btUpdKind      <= kindCond;
        bpUpdValid     <= 1'b0;
        bpUpdPc        <= '0;
        bpUpdHistory   <= '0;
        bpUpdTaken     <= 1'b0;
        bpUpdPredTaken <= 1'b0;
        bpUpdProvider  <= 1'b0;
        mispr          <= 1'b0;
        misprHist      <= '0;
        misprRetIdx    <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        waitReady(ready);
        if (!ready) begin
            $display("timed out waiting for the predictor to leave reset");
            $display("Simulation failed");
            $finish;
        end else begin
            testResetLookups();
            testBtbInstall();
            testCondTraining();
            testReturnStack();
            testMispredict();
            $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
            if (errCount == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* branchPredictor.sv */
`timescale 1ns/1ns
`default_nettype none

module branchPredictor import bpPkg::*; (
    input  logic        clk,
    input  logic        rst,

    // fetch lookup.
    input  logic        pcValid,
    input  logic [31:0] pc,
    output logic        predTaken,
    output logic [31:0] predTarget,
    output brKind_t     predKind,
    output logic        predHit,
    output bHist_t      history,
    output logic        provider,
    output retIdx_t     retIdx,

    // execute target update.
    input  logic        btUpdValid,
    input  logic [31:0] btUpdPc,
    input  logic [31:0] btUpdTarget,
    input  brKind_t     btUpdKind,

    // commit direction update.
    input  logic        bpUpdValid,
    input  logic [31:0] bpUpdPc,
    input  bHist_t      bpUpdHistory,
    input  logic        bpUpdTaken,
    input  logic        bpUpdPredTaken,
    input  logic        bpUpdProvider,

    // mispredict restore.
    input  logic        mispr,
    input  bHist_t      misprHist,
    input  retIdx_t     misprRetIdx
);

    addr_t   fetchAddr;
    addr_t   retAddr;
    bHist_t  gHistory;

    logic    btbHit;
    addr_t   btbTarget;
    brKind_t btbKind;

    logic    dirTaken;
    logic    dirProvider;

    addr_t   retTop;
    retIdx_t retCurIdx;
    logic    retPush;
    logic    retPop;

    logic    condHit;
    logic    dirUpdValid;

    assign fetchAddr = pc[31:2];
    assign retAddr   = fetchAddr + addr_t'(1); // pc plus 4.

    // ##############################
    // tables
    branchTargetBuffer btb (
        .clk         (clk),
        .rst         (rst),
        .lookupValid (pcValid),
        .lookupAddr  (fetchAddr),
        .hit         (btbHit),
        .target      (btbTarget),
        .kind        (btbKind),
        .updValid    (btUpdValid),
        .updAddr     (btUpdPc[31:2]),
        .updTarget   (btUpdTarget[31:2]),
        .updKind     (btUpdKind)
    );

    // stale commits are dropped while a mispredict restores state.
    assign dirUpdValid = bpUpdValid && !mispr;

    taggedPredictor tagPred (
        .clk          (clk),
        .rst          (rst),
        .predAddr     (fetchAddr),
        .predHist     (gHistory),
        .predTaken    (dirTaken),
        .provider     (dirProvider),
        .updValid     (dirUpdValid),
        .updAddr      (bpUpdPc[31:2]),
        .updHist      (bpUpdHistory),
        .updTaken     (bpUpdTaken),
        .updPredTaken (bpUpdPredTaken),
        .updProvider  (bpUpdProvider)
    );

    assign retPush = btbHit && (btbKind == kindCall);
    assign retPop  = btbHit && (btbKind == kindRet);

    returnStack retStack (
        .clk      (clk),
        .rst      (rst),
        .push     (retPush),
        .pushAddr (retAddr),
        .pop      (retPop),
        .setIdx   (mispr),
        .idx      (misprRetIdx),
        .topAddr  (retTop),
        .curIdx   (retCurIdx)
    );

    // ##############################
    // selection
    always_comb begin
        predTaken  = 1'b0;
        predTarget = {btbTarget, 2'b00};
        case (btbKind)
            kindCond: predTaken = btbHit && dirTaken;
            kindJump,
            kindCall: predTaken = btbHit;
            kindRet: begin
                predTaken  = btbHit;
                predTarget = {retTop, 2'b00}; // stack top.
            end
        endcase
    end

    assign predHit  = btbHit;
    assign predKind = btbKind;
    assign provider = dirProvider;
    assign retIdx   = retCurIdx;
    assign history  = gHistory;

    // ##############################
    // speculative history
    assign condHit = btbHit && (btbKind == kindCond);

    always_ff @(posedge clk) begin
        if (rst) begin
            gHistory <= '0;
        end else if (mispr) begin
            gHistory <= misprHist;
        end else if (condHit) begin
            gHistory <= {gHistory[histBits-2:0], predTaken};
        end
    end

endmodule

`default_nettype wire

/* branchTargetBuffer.sv */
`timescale 1ns/1ns
`default_nettype none

module branchTargetBuffer import bpPkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    lookupValid,
    input  addr_t   lookupAddr,
    output logic    hit,
    output addr_t   target,
    output brKind_t kind,

    input  logic    updValid,
    input  addr_t   updAddr,
    input  addr_t   updTarget,
    input  brKind_t updKind
);

    logic [btbEntries-1:0] entryValid;
    btbTag_t               entryTag    [btbEntries];
    addr_t                 entryTarget [btbEntries];
    brKind_t               entryKind   [btbEntries];

    // ##############################
    // lookup
    btbIdx_t lookupIdx;
    btbTag_t lookupTag;
    logic    tagMatch;

    assign lookupIdx = btbIndex(lookupAddr);
    assign lookupTag = btbTag(lookupAddr);
    assign tagMatch  = (entryTag[lookupIdx] == lookupTag);

    assign hit    = lookupValid && entryValid[lookupIdx] && tagMatch;
    assign target = entryTarget[lookupIdx];
    assign kind   = entryKind[lookupIdx];

    // ##############################
    // install
    btbIdx_t updIdx;

    assign updIdx = btbIndex(updAddr);

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (updValid) begin
            entryValid[updIdx] <= 1'b1;
        end
    end

    // payload, overwritten on every install.
    always_ff @(posedge clk) begin
        if (updValid) begin
            entryTag[updIdx]    <= btbTag(updAddr);
            entryTarget[updIdx] <= updTarget;
            entryKind[updIdx]   <= updKind;
        end
    end

endmodule

`default_nettype wire

/* flist.f */
bpPkg.sv
branchTargetBuffer.sv
taggedPredictor.sv
returnStack.sv
branchPredictor.sv
bpChk.sv
bpTb.sv

/* returnStack.sv */
`timescale 1ns/1ns
`default_nettype none

module returnStack import bpPkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    push,
    input  addr_t   pushAddr,
    input  logic    pop,

    // mispredict restore.
    input  logic    setIdx,
    input  retIdx_t idx,

    output addr_t   topAddr,
    output retIdx_t curIdx
);

    addr_t   stackMem [retDepth];
    retIdx_t ptr;
    retIdx_t pushIdx;
    retIdx_t popIdx;

    // pointer wraps, oldest entries get overwritten.
    assign pushIdx = ptr + retIdx_t'(1);
    assign popIdx  = ptr - retIdx_t'(1);

    assign curIdx  = ptr;
    assign topAddr = stackMem[ptr];

    // ##############################
    // pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (setIdx) begin
            ptr <= idx;
        end else if (push) begin
            ptr <= pushIdx;
        end else if (pop) begin
            ptr <= popIdx;
        end
    end

    // ##############################
    // storage
    always_ff @(posedge clk) begin
        if (push && !setIdx) begin
            stackMem[pushIdx] <= pushAddr;
        end
    end

endmodule

`default_nettype wire

/* taggedPredictor.sv */
`timescale 1ns/1ns
`default_nettype none

module taggedPredictor import bpPkg::*; (
    input  logic   clk,
    input  logic   rst,

    // fetch side lookup.
    input  addr_t  predAddr,
    input  bHist_t predHist,
    output logic   predTaken,
    output logic   provider,

    // commit side update.
    input  logic   updValid,
    input  addr_t  updAddr,
    input  bHist_t updHist,
    input  logic   updTaken,
    input  logic   updPredTaken,
    input  logic   updProvider
);

    ctr_t                  baseCtr   [baseEntries];
    logic [tagEntries-1:0] tagValid;
    tagTag_t               tagTagMem [tagEntries];
    ctr_t                  tagCtr    [tagEntries];

    // ##############################
    // lookup
    baseIdx_t predBaseIdx;
    tagIdx_t  predTagIdx;
    logic     predTagHit;

    assign predBaseIdx = baseIndex(predAddr);
    assign predTagIdx  = tagIndex(predAddr, predHist);
    assign predTagHit  = tagValid[predTagIdx] &&
                         (tagTagMem[predTagIdx] == tagTag(predAddr));

    assign provider  = predTagHit;
    assign predTaken = predTagHit ? tagCtr[predTagIdx][1] : baseCtr[predBaseIdx][1];

    // ##############################
    // update
    baseIdx_t updBaseIdx;
    tagIdx_t  updTagIdx;
    tagTag_t  updTag;
    logic     updTagHit;
    logic     updMispred;
    logic     updAlloc;

    // index with the history the branch saw at fetch.
    assign updBaseIdx = baseIndex(updAddr);
    assign updTagIdx  = tagIndex(updAddr, updHist);
    assign updTag     = tagTag(updAddr);
    assign updTagHit  = tagValid[updTagIdx] && (tagTagMem[updTagIdx] == updTag);
    assign updMispred = (updTaken != updPredTaken);
    assign updAlloc   = !updTagHit && updMispred && !updProvider;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < baseEntries; i++) begin
                baseCtr[i] <= ctrWeakNotTaken;
            end
        end else if (updValid) begin
            baseCtr[updBaseIdx] <= ctrNext(baseCtr[updBaseIdx], updTaken);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tagValid <= '0;
        end else if (updValid && updAlloc) begin
            tagValid[updTagIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updValid) begin
            if (updTagHit) begin
                tagCtr[updTagIdx] <= ctrNext(tagCtr[updTagIdx], updTaken);
            end else if (updAlloc) begin
                tagTagMem[updTagIdx] <= updTag;
                tagCtr[updTagIdx]    <= updTaken ? ctrWeakTaken : ctrWeakNotTaken; // weak start.
            end
        end
    end

endmodule

`default_nettype wire
